//--- eth_stat_quad.f
verilog/stat_pkg.sv
verilog/stat_reset_sync.sv
verilog/stat_collector.sv
verilog/stat_arb_mux.sv
verilog/eth_stat_quad.sv
verification/stat_checker.sv
verification/tb_eth_stat_quad.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the statistics quad simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_eth_stat_quad \
    -f eth_stat_quad.f \
    -o sim_eth_stat_quad

out=$(./obj_dir/sim_eth_stat_quad)
echo "$out"
echo "$out" | grep -q "TEST PASSED"

//--- verification/stat_checker.sv
// Statistics output checker
`timescale 1ns/1ps

module stat_checker (
    input  logic                            stat_clk,
    input  logic                            arst_n,
    input  logic [stat_pkg::NUM_CH-1:0]      stat_tx_pkt_good,
    input  logic [stat_pkg::NUM_CH-1:0]      stat_rx_pkt_good,
    input  logic [stat_pkg::NUM_CH-1:0]      stat_rx_err_bad_fcs,
    input  logic [stat_pkg::BYTE_INC_W-1:0]  stat_tx_byte [stat_pkg::NUM_CH],
    input  logic                            stat_credit,
    input  logic                            stat_valid,
    input  logic [stat_pkg::STAT_ID_W-1:0]   stat_id,
    input  logic [stat_pkg::STAT_VAL_W-1:0]  stat_val,
    input  logic                            credit_hold,
    input  logic                            drain_done,
    output logic                            report_done,
    output int                              fail_count
);

    import stat_pkg::*;

    localparam int NUM_ID = NUM_CH * STAT_PER_CH;

    int   expected [NUM_ID];
    int   observed [NUM_ID];
    int   outstanding = 0;
    int   peak = 0;
    int   hold_words = 0;
    int   windows = 0;
    int   reset_errs = 0;
    int   credit_errs = 0;
    int   word_errs = 0;
    int   tests = 0;
    int   failed = 0;
    logic hold_prev = 1'b0;
    logic done_q = 1'b0;

    assign report_done = done_q;
    assign fail_count = failed;

    task automatic close_test(input string name, input int errs, input string detail);
        tests++;
        if (errs == 0) begin
            $display("[%0t] %s: passed, %s", $time, name, detail);
        end else begin
            failed++;
            $display("[%0t] %s: failed with %0d errors, %s", $time, name, errs, detail);
        end
    endtask

    // One stat over all channels, ID is channel base plus stat index
    task automatic check_totals(input int sel, input string name);
        int errs;
        int id;
        int total;
        errs = 0;
        total = 0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            id = ch * STAT_PER_CH + sel;
            total += expected[id];
            if (observed[id] != expected[id]) begin
                errs++;
                $display("MISMATCH at %0t: id %0d summed to %0d, expected %0d",
                         $time, id, observed[id], expected[id]);
            end
        end
        close_test(name, errs, $sformatf("%0d counted", total));
    endtask

    always @(posedge stat_clk) begin
        if (!arst_n) begin
            if (stat_valid) begin
                reset_errs++;
                $display("MISMATCH at %0t: stat_valid high during reset", $time);
            end
            outstanding = 0;
            for (int i = 0; i < NUM_ID; i++) begin
                expected[i] = 0;
                observed[i] = 0;
            end
        end else begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                expected[ch * STAT_PER_CH + int'(STAT_TX_PKT)] += int'(stat_tx_pkt_good[ch]);
                expected[ch * STAT_PER_CH + int'(STAT_RX_PKT)] += int'(stat_rx_pkt_good[ch]);
                expected[ch * STAT_PER_CH + int'(STAT_RX_BAD_FCS)] +=
                    int'(stat_rx_err_bad_fcs[ch]);
                expected[ch * STAT_PER_CH + int'(STAT_TX_BYTES)] += int'(stat_tx_byte[ch]);
            end
            outstanding = outstanding + int'(stat_valid) - int'(stat_credit);
            if (outstanding > peak) begin
                peak = outstanding;
            end
            if (outstanding > CREDIT_MAX || outstanding < 0) begin
                credit_errs++;
                $display("MISMATCH at %0t: %0d words outstanding, limit %0d",
                         $time, outstanding, CREDIT_MAX);
            end
            if (stat_valid) begin
                if (int'(stat_id) >= NUM_ID) begin
                    word_errs++;
                    $display("MISMATCH at %0t: stat_id %0d out of range", $time, stat_id);
                end else begin
                    observed[int'(stat_id)] += int'(stat_val);
                end
                if (stat_val == '0) begin
                    word_errs++;
                    $display("MISMATCH at %0t: zero delta for id %0d", $time, stat_id);
                end
                if (credit_hold && hold_prev) begin
                    hold_words++;
                end
            end
        end
        // Window closes once credits flow again
        if (hold_prev && !credit_hold) begin
            windows++;
            if (hold_words > CREDIT_MAX) begin
                $display("MISMATCH at %0t: %0d words with credits withheld, limit %0d",
                         $time, hold_words, CREDIT_MAX);
            end
            close_test($sformatf("stall window %0d", windows), int'(hold_words > CREDIT_MAX),
                       $sformatf("%0d words while credits withheld", hold_words));
            hold_words = 0;
        end
        hold_prev = credit_hold;
        if (drain_done && !done_q) begin
            close_test("reset quiet", reset_errs, "stat_valid low in reset");
            close_test("credit limit", credit_errs, $sformatf("peak %0d outstanding", peak));
            close_test("word format", word_errs, "ids in range, deltas nonzero");
            check_totals(int'(STAT_TX_PKT), "tx packet totals");
            check_totals(int'(STAT_RX_PKT), "rx packet totals");
            check_totals(int'(STAT_RX_BAD_FCS), "bad fcs totals");
            check_totals(int'(STAT_TX_BYTES), "tx byte totals");
            $display("Summary: %0d tests, %0d passed, %0d failed", tests, tests - failed, failed);
            done_q = 1'b1;
        end
    end

endmodule

//--- verification/tb_eth_stat_quad.sv
// Statistics quad testbench
`timescale 1ns/1ps

module tb_eth_stat_quad;

    import stat_pkg::*;

    localparam int SEED = 39943;
    localparam int NUM_ROWS = 6;
    localparam int RESET_CYCLES = 4;
    localparam int TIMEOUT_MARGIN = 4 * STAT_UPDATE_PERIOD;

    // Strobe enables per channel, byte increment, row length, credit mode
    typedef struct {
        logic [NUM_CH-1:0]     tx_en;
        logic [NUM_CH-1:0]     rx_en;
        logic [NUM_CH-1:0]     fcs_en;
        logic [BYTE_INC_W-1:0] byte_inc;
        int                    cycles;
        logic                  hold;
    } stim_row_t;

    logic                  stat_clk = 1'b0;
    logic                  arst_n;
    logic [NUM_CH-1:0]     stat_tx_pkt_good;
    logic [NUM_CH-1:0]     stat_rx_pkt_good;
    logic [NUM_CH-1:0]     stat_rx_err_bad_fcs;
    logic [BYTE_INC_W-1:0] stat_tx_byte [NUM_CH];
    logic                  stat_credit;
    logic                  stat_valid;
    logic [STAT_ID_W-1:0]  stat_id;
    logic [STAT_VAL_W-1:0] stat_val;
    logic                  credit_hold;
    logic                  drain_done;
    logic                  report_done;
    int                    fail_count;
    stim_row_t             rows [NUM_ROWS];
    int                    owed = 0;
    logic                  valid_seen = 1'b0;
    int                    cycle_count = 0;
    int                    timeout_limit = 0;

    always #20 stat_clk = ~stat_clk;

    eth_stat_quad i_eth_stat_quad (.*);

    stat_checker i_stat_checker (.*);

    task automatic set_row(input int r, input logic [NUM_CH-1:0] tx, rx, fcs,
                           input logic [BYTE_INC_W-1:0] inc, input int cycles, input logic hold);
        rows[r].tx_en = tx;
        rows[r].rx_en = rx;
        rows[r].fcs_en = fcs;
        rows[r].byte_inc = inc;
        rows[r].cycles = cycles;
        rows[r].hold = hold;
    endtask

    // Random bits gate each enabled strobe
    task automatic drive_events(input int r);
        int unsigned rnd;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            rnd = $urandom;
            stat_tx_pkt_good[ch] <= rows[r].tx_en[ch] & rnd[0];
            stat_rx_pkt_good[ch] <= rows[r].rx_en[ch] & rnd[1];
            stat_rx_err_bad_fcs[ch] <= rows[r].fcs_en[ch] & rnd[2];
            stat_tx_byte[ch] <= rnd[3] ? rows[r].byte_inc : '0;
        end
    endtask

    // Credit goes back two cycles after the word, held rows build a backlog
    task automatic return_credit(input logic hold);
        logic give;
        give = 1'b0;
        owed = owed + int'(valid_seen);
        valid_seen = stat_valid;
        if (!hold && owed > 0) begin
            give = 1'b1;
            owed--;
        end
        stat_credit <= give;
        credit_hold <= hold;
    endtask

    always @(posedge stat_clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: no checker report after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int total;
        void'($urandom(SEED));
        arst_n <= 1'b0;
        stat_tx_pkt_good <= '0;
        stat_rx_pkt_good <= '0;
        stat_rx_err_bad_fcs <= '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            stat_tx_byte[ch] <= '0;
        end
        stat_credit <= 1'b0;
        credit_hold <= 1'b0;
        drain_done <= 1'b0;
        // Held rows span a flush so records stall
        set_row(0, 4'hF, 4'hF, 4'hF, 4'd5, 150, 1'b0);
        set_row(1, 4'h5, 4'h0, 4'h0, 4'd15, 100, 1'b0);
        set_row(2, 4'hF, 4'hF, 4'hF, 4'd9, 160, 1'b1);
        set_row(3, 4'h0, 4'hA, 4'hA, 4'd3, 90, 1'b0);
        set_row(4, 4'hF, 4'h3, 4'hC, 4'd7, 80, 1'b1);
        set_row(5, 4'h0, 4'h0, 4'h0, 4'd0, 3 * STAT_UPDATE_PERIOD, 1'b0);
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += rows[r].cycles;
        end
        timeout_limit = total + TIMEOUT_MARGIN;
        repeat (RESET_CYCLES) @(posedge stat_clk);
        arst_n <= 1'b1;
        repeat (SYNC_STAGES + 2) @(posedge stat_clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < rows[r].cycles; c++) begin
                @(posedge stat_clk);
                drive_events(r);
                return_credit(rows[r].hold);
            end
        end
        @(posedge stat_clk);
        drain_done <= 1'b1;
        while (!report_done) @(posedge stat_clk);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/eth_stat_quad.sv
// Quad Ethernet MAC statistics
`timescale 1ns/1ps

module eth_stat_quad (
    input  logic                            stat_clk,
    input  logic                            arst_n,
    input  logic [stat_pkg::NUM_CH-1:0]      stat_tx_pkt_good,
    input  logic [stat_pkg::NUM_CH-1:0]      stat_rx_pkt_good,
    input  logic [stat_pkg::NUM_CH-1:0]      stat_rx_err_bad_fcs,
    input  logic [stat_pkg::BYTE_INC_W-1:0]  stat_tx_byte [stat_pkg::NUM_CH],
    input  logic                            stat_credit,
    output logic                            stat_valid,
    output logic [stat_pkg::STAT_ID_W-1:0]   stat_id,
    output logic [stat_pkg::STAT_VAL_W-1:0]  stat_val
);

    import stat_pkg::*;

    logic                  rst_n_sync;
    logic [NUM_CH-1:0]     rec_valid;
    logic [NUM_CH-1:0]     rec_ready;
    logic [STAT_ID_W-1:0]  rec_id [NUM_CH];
    logic [STAT_VAL_W-1:0] rec_val [NUM_CH];

    stat_reset_sync i_stat_reset_sync (
        .stat_clk   (stat_clk),
        .arst_n     (arst_n),
        .rst_n_sync (rst_n_sync)
    );

    // Each channel owns STAT_PER_CH consecutive IDs
    for (genvar n = 0; n < NUM_CH; n++) begin : g_ch
        stat_collector #(
            .STAT_ID_BASE (n * STAT_PER_CH)
        ) i_stat_collector (
            .stat_clk       (stat_clk),
            .rst_n_sync     (rst_n_sync),
            .tx_pkt_good    (stat_tx_pkt_good[n]),
            .rx_pkt_good    (stat_rx_pkt_good[n]),
            .rx_err_bad_fcs (stat_rx_err_bad_fcs[n]),
            .tx_byte        (stat_tx_byte[n]),
            .rec_valid      (rec_valid[n]),
            .rec_id         (rec_id[n]),
            .rec_val        (rec_val[n]),
            .rec_ready      (rec_ready[n])
        );
    end

    stat_arb_mux i_stat_arb_mux (
        .stat_clk    (stat_clk),
        .rst_n_sync  (rst_n_sync),
        .rec_valid   (rec_valid),
        .rec_id      (rec_id),
        .rec_val     (rec_val),
        .rec_ready   (rec_ready),
        .stat_credit (stat_credit),
        .stat_valid  (stat_valid),
        .stat_id     (stat_id),
        .stat_val    (stat_val)
    );

endmodule

//--- verilog/stat_arb_mux.sv
// Statistics round-robin arbiter
`timescale 1ns/1ps

module stat_arb_mux (
    input  logic                           stat_clk,
    input  logic                           rst_n_sync,
    input  logic [stat_pkg::NUM_CH-1:0]     rec_valid,
    input  logic [stat_pkg::STAT_ID_W-1:0]  rec_id [stat_pkg::NUM_CH],
    input  logic [stat_pkg::STAT_VAL_W-1:0] rec_val [stat_pkg::NUM_CH],
    output logic [stat_pkg::NUM_CH-1:0]     rec_ready,
    input  logic                           stat_credit,
    output logic                           stat_valid,
    output logic [stat_pkg::STAT_ID_W-1:0]  stat_id,
    output logic [stat_pkg::STAT_VAL_W-1:0] stat_val
);

    import stat_pkg::*;

    logic [CREDIT_W-1:0] credit_cnt;
    logic [CH_IDX_W-1:0] last_grant;
    logic [CH_IDX_W-1:0] grant_idx;
    logic                grant_any;

    // Search starts one past the last granted channel
    always_comb begin
        int idx;
        grant_any = 1'b0;
        grant_idx = last_grant;
        for (int k = 1; k <= NUM_CH; k++) begin
            idx = (int'(last_grant) + k) % NUM_CH;
            if (!grant_any && rec_valid[idx] && credit_cnt != '0) begin
                grant_any = 1'b1;
                grant_idx = CH_IDX_W'(idx);
            end
        end
    end

    always_comb begin
        rec_ready = '0;
        if (grant_any) begin
            rec_ready[grant_idx] = 1'b1;
        end
    end

    // Credit spent at grant time and the word follows on the next edge
    always_ff @(posedge stat_clk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            credit_cnt <= CREDIT_W'(CREDIT_MAX);
            last_grant <= CH_IDX_W'(NUM_CH - 1);
            stat_valid <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt - CREDIT_W'(grant_any) + CREDIT_W'(stat_credit);
            stat_valid <= grant_any;
            if (grant_any) begin
                last_grant <= grant_idx;
            end
        end
    end

    always_ff @(posedge stat_clk) begin
        if (grant_any) begin
            stat_id <= rec_id[grant_idx];
            stat_val <= rec_val[grant_idx];
        end
    end

    a_credit_max: assert property (
        @(posedge stat_clk) disable iff (!rst_n_sync)
        credit_cnt <= CREDIT_W'(CREDIT_MAX)
    );

endmodule

//--- verilog/stat_collector.sv
// Per-channel statistics collector
`timescale 1ns/1ps

module stat_collector #(
    parameter int STAT_ID_BASE = 0
) (
    input  logic                           stat_clk,
    input  logic                           rst_n_sync,
    input  logic                           tx_pkt_good,
    input  logic                           rx_pkt_good,
    input  logic                           rx_err_bad_fcs,
    input  logic [stat_pkg::BYTE_INC_W-1:0] tx_byte,
    output logic                           rec_valid,
    output logic [stat_pkg::STAT_ID_W-1:0]  rec_id,
    output logic [stat_pkg::STAT_VAL_W-1:0] rec_val,
    input  logic                           rec_ready
);

    import stat_pkg::*;

    collect_state_e        state;
    stat_sel_e             sel;
    logic [PERIOD_W-1:0]   period_cnt;
    logic                  period_tick;
    logic                  xfer;
    logic                  last_sel;
    logic [STAT_VAL_W-1:0] acc [STAT_PER_CH];
    logic [STAT_VAL_W-1:0] inc [STAT_PER_CH];

    assign period_tick = (period_cnt == PERIOD_W'(STAT_UPDATE_PERIOD - 1));
    assign xfer = rec_valid && rec_ready;
    assign last_sel = (sel == STAT_TX_BYTES);

    // This cycle's increments, one per stat
    always_comb begin
        inc[STAT_TX_PKT] = STAT_VAL_W'(tx_pkt_good);
        inc[STAT_RX_PKT] = STAT_VAL_W'(rx_pkt_good);
        inc[STAT_RX_BAD_FCS] = STAT_VAL_W'(rx_err_bad_fcs);
        inc[STAT_TX_BYTES] = STAT_VAL_W'(tx_byte);
    end

    // Free-running period counter from reset release
    always_ff @(posedge stat_clk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            period_cnt <= '0;
        end else if (period_tick) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // Reported amount leaves the accumulator, new events still land
    always_ff @(posedge stat_clk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            for (int i = 0; i < STAT_PER_CH; i++) begin
                acc[i] <= '0;
            end
        end else begin
            for (int i = 0; i < STAT_PER_CH; i++) begin
                if (xfer && sel == stat_sel_e'(i)) begin
                    acc[i] <= acc[i] + inc[i] - rec_val;
                end else begin
                    acc[i] <= acc[i] + inc[i];
                end
            end
        end
    end

    // Scan FSM, a period tick during a scan is dropped
    always_ff @(posedge stat_clk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            state <= COLLECT_IDLE;
            sel <= STAT_TX_PKT;
            rec_valid <= 1'b0;
        end else begin
            case (state)
                COLLECT_IDLE: begin
                    if (period_tick) begin
                        state <= COLLECT_SCAN;
                        sel <= STAT_TX_PKT;
                    end
                end
                COLLECT_SCAN: begin
                    if (rec_valid) begin
                        if (rec_ready) begin
                            rec_valid <= 1'b0;
                            if (last_sel) begin
                                state <= COLLECT_IDLE;
                            end else begin
                                sel <= stat_sel_e'(sel + 2'd1);
                            end
                        end
                    end else if (acc[sel] != '0) begin
                        rec_valid <= 1'b1;
                    end else if (last_sel) begin
                        state <= COLLECT_IDLE;
                    end else begin
                        sel <= stat_sel_e'(sel + 2'd1);
                    end
                end
                default: state <= COLLECT_IDLE;
            endcase
        end
    end

    // Record payload, captured once per nonzero stat
    always_ff @(posedge stat_clk) begin
        if (state == COLLECT_SCAN && !rec_valid && acc[sel] != '0) begin
            rec_val <= acc[sel];
            rec_id <= STAT_ID_W'(STAT_ID_BASE) + STAT_ID_W'(sel);
        end
    end

    a_rec_hold: assert property (
        @(posedge stat_clk) disable iff (!rst_n_sync)
        (rec_valid && !rec_ready) |=> (rec_valid && $stable(rec_id) && $stable(rec_val))
    );

endmodule

//--- verilog/stat_pkg.sv
// Statistics quad shared definitions
package stat_pkg;

    // Channel and statistic counts
    localparam int NUM_CH = 4;
    localparam int STAT_PER_CH = 4;

    // Record field widths
    localparam int STAT_ID_W = 8;
    localparam int STAT_VAL_W = 16;
    localparam int BYTE_INC_W = 4;

    // Flush timing and output flow control
    localparam int STAT_UPDATE_PERIOD = 64;
    localparam int CREDIT_MAX = 4;
    localparam int SYNC_STAGES = 4;

    // Derived widths
    localparam int CH_IDX_W = $clog2(NUM_CH);
    localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);
    localparam int PERIOD_W = $clog2(STAT_UPDATE_PERIOD);

    // Stat index inside a channel, added to the channel ID base
    typedef enum logic [1:0] {
        STAT_TX_PKT     = 2'd0,
        STAT_RX_PKT     = 2'd1,
        STAT_RX_BAD_FCS = 2'd2,
        STAT_TX_BYTES   = 2'd3
    } stat_sel_e;

    typedef enum logic {
        COLLECT_IDLE = 1'b0,
        COLLECT_SCAN = 1'b1
    } collect_state_e;

endpackage

//--- verilog/stat_reset_sync.sv
// Statistics reset synchronizer
`timescale 1ns/1ps

module stat_reset_sync (
    input  logic stat_clk,
    input  logic arst_n,
    output logic rst_n_sync
);

    import stat_pkg::*;

    logic [SYNC_STAGES-1:0] sync_chain;

    // Clears at once, fills with ones after release
    always_ff @(posedge stat_clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_chain <= '0;
        end else begin
            sync_chain <= {sync_chain[SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign rst_n_sync = sync_chain[SYNC_STAGES-1];

endmodule
